/* src/npu_pkg.sv */
package npu_pkg;

    // =========================================================================
    // Sizes
    // =========================================================================
    localparam int INSTR_W    = 128;
    localparam int UC_DEPTH   = 256;
    localparam int UC_AW      = 8;
    localparam int DATA_DEPTH = 4096;
    localparam int DATA_AW    = 12;

    // Opcodes
    localparam logic [7:0] OP_NOP     = 8'h00;
    localparam logic [7:0] OP_VEC     = 8'h01;
    localparam logic [7:0] OP_DMA_RD  = 8'h02;
    localparam logic [7:0] OP_DMA_WR  = 8'h03;
    localparam logic [7:0] OP_BARRIER = 8'h04;
    localparam logic [7:0] OP_END     = 8'hFF;

    // Engine slots in the scoreboard
    localparam int               NUM_ENGINES = 2;
    localparam int               ENG_W       = 1;
    localparam logic [ENG_W-1:0] ENG_VEC     = 1'd0;
    localparam logic [ENG_W-1:0] ENG_DMA     = 1'd1;

    // Vector ops, taken from flags[1:0]
    localparam logic [1:0] VEC_ADD   = 2'd0;
    localparam logic [1:0] VEC_SUB   = 2'd1;
    localparam logic [1:0] VEC_SCALE = 2'd2;
    localparam logic [1:0] VEC_COPY  = 2'd3;

    // =========================================================================
    // Instruction and command formats
    // =========================================================================
    // imm carries scale in [7:0] and shift in [15:8] for VEC_SCALE
    typedef struct packed {
        logic [7:0]  opcode;
        logic [7:0]  flags;
        logic [15:0] dst;
        logic [15:0] src0;
        logic [15:0] src1;
        logic [15:0] len;
        logic [15:0] imm;
        logic [31:0] rsvd;
    } ucode_instr_t;

    typedef struct packed {
        logic [1:0]  op;
        logic [15:0] src0;
        logic [15:0] src1;
        logic [15:0] dst;
        logic [15:0] len;
        logic [7:0]  scale;
        logic [7:0]  shift;
    } vec_cmd_t;

    typedef struct packed {
        logic        is_write;
        logic [15:0] src;
        logic [15:0] dst;
        logic [15:0] len;
        logic [7:0]  flags;
    } dma_cmd_t;

    typedef struct packed {
        logic               en;
        logic [UC_AW-1:0]   addr;
        logic [INSTR_W-1:0] data;
    } ucode_wr_t;

    typedef struct packed {
        logic               en;
        logic [DATA_AW-1:0] addr;
        logic [7:0]         data;
    } mem_wr_t;

    typedef struct packed {
        logic               en;
        logic [DATA_AW-1:0] addr;
    } mem_rd_t;

endpackage

/* src/dp_sram.sv */
`timescale 1ns/1ps

module dp_sram #(
    parameter type word_t = logic [7:0],
    parameter int  DEPTH  = 256
) (
    input  logic                     clk,
    input  logic                     rd_en,
    input  logic [$clog2(DEPTH)-1:0] rd_addr,
    output word_t                    rd_data,
    input  logic                     wr_en,
    input  logic [$clog2(DEPTH)-1:0] wr_addr,
    input  word_t                    wr_data
);

    word_t mem [DEPTH];

    // Registered read, output holds until the next read
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

endmodule

/* src/ucode_fetch.sv */
`timescale 1ns/1ps

module ucode_fetch
    import npu_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start,
    input  logic [UC_AW:0]   ucode_len,
    output logic             rd_en,
    output logic [UC_AW-1:0] rd_addr,
    input  ucode_instr_t     rd_data,
    output logic             instr_valid,
    output ucode_instr_t     instr,
    input  logic             instr_ready,
    output logic             fetch_done
);

    logic           running;
    logic [UC_AW:0] pc;
    logic [UC_AW:0] sent_cnt;
    logic           rd_tag;
    logic           xfer;
    logic           move;
    logic           end_hit;
    logic           len_hit;
    logic           stop;

    assign xfer    = instr_valid && instr_ready;
    // Memory output holds its word until the buffer frees up
    assign move    = rd_tag && (!instr_valid || xfer);
    assign end_hit = move && (rd_data.opcode == OP_END);
    assign len_hit = running && (sent_cnt == ucode_len);
    assign stop    = running && (end_hit || len_hit);

    assign rd_en      = running && !stop && (pc < ucode_len) && (!rd_tag || move);
    assign rd_addr    = pc[UC_AW-1:0];
    assign fetch_done = stop;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            running     <= 1'b0;
            pc          <= '0;
            sent_cnt    <= '0;
            rd_tag      <= 1'b0;
            instr_valid <= 1'b0;
        end else if (start) begin
            running     <= 1'b1;
            pc          <= '0;
            sent_cnt    <= '0;
            rd_tag      <= 1'b0;
            instr_valid <= 1'b0;
        end else begin
            if (stop) begin
                running <= 1'b0;
            end
            if (rd_en) begin
                pc <= pc + 1'b1;
            end
            if (xfer) begin
                sent_cnt <= sent_cnt + 1'b1;
            end
            rd_tag <= rd_en || (rd_tag && !move && !stop);
            // END is dropped here and never reaches decode
            if (move && !end_hit) begin
                instr_valid <= 1'b1;
            end else if (xfer) begin
                instr_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (move && !end_hit) begin
            instr <= rd_data;
        end
    end

    // A stalled word stays put until decode takes it
    assert property (@(posedge clk) disable iff (!rst_n)
        instr_valid && !instr_ready && !start |=> instr_valid && $stable(instr));

endmodule

/* src/ucode_decode.sv */
`timescale 1ns/1ps

module ucode_decode
    import npu_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   instr_valid,
    input  ucode_instr_t           instr,
    output logic                   instr_ready,
    input  logic [NUM_ENGINES-1:0] can_issue,
    input  logic                   all_idle,
    output logic                   vec_cmd_valid,
    output vec_cmd_t               vec_cmd,
    output logic                   dma_cmd_valid,
    output dma_cmd_t               dma_cmd,
    output logic                   issue_valid,
    output logic [ENG_W-1:0]       issue_engine
);

    logic is_vec;
    logic is_dma;
    logic accept;

    assign is_vec = instr.opcode == OP_VEC;
    assign is_dma = (instr.opcode == OP_DMA_RD) || (instr.opcode == OP_DMA_WR);

    // One stall decision covers busy engines and a pending barrier
    always_comb begin
        case (instr.opcode)
            OP_VEC:               instr_ready = can_issue[ENG_VEC];
            OP_DMA_RD, OP_DMA_WR: instr_ready = can_issue[ENG_DMA];
            OP_BARRIER:           instr_ready = all_idle;
            OP_NOP:               instr_ready = 1'b1;
            default:              instr_ready = 1'b1;
        endcase
    end

    assign accept        = instr_valid && instr_ready;
    assign vec_cmd_valid = accept && is_vec;
    assign dma_cmd_valid = accept && is_dma;
    assign issue_valid   = vec_cmd_valid || dma_cmd_valid;
    assign issue_engine  = is_vec ? ENG_VEC : ENG_DMA;

    always_comb begin
        vec_cmd.op    = instr.flags[1:0];
        vec_cmd.src0  = instr.src0;
        vec_cmd.src1  = instr.src1;
        vec_cmd.dst   = instr.dst;
        vec_cmd.len   = instr.len;
        vec_cmd.scale = instr.imm[7:0];
        vec_cmd.shift = instr.imm[15:8];
    end

    always_comb begin
        dma_cmd.is_write = instr.opcode == OP_DMA_WR;
        dma_cmd.src      = instr.src0;
        dma_cmd.dst      = instr.dst;
        dma_cmd.len      = instr.len;
        dma_cmd.flags    = instr.flags;
    end

    // Scoreboard must block a back-to-back issue to the same engine
    assert property (@(posedge clk) disable iff (!rst_n)
        vec_cmd_valid |=> !vec_cmd_valid);
    assert property (@(posedge clk) disable iff (!rst_n)
        dma_cmd_valid |=> !dma_cmd_valid);

endmodule

/* src/engine_scoreboard.sv */
`timescale 1ns/1ps

module engine_scoreboard
    import npu_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   issue_valid,
    input  logic [ENG_W-1:0]       issue_engine,
    input  logic [NUM_ENGINES-1:0] engine_done,
    output logic [NUM_ENGINES-1:0] can_issue,
    output logic                   all_idle
);

    logic [NUM_ENGINES-1:0] busy;
    logic [NUM_ENGINES-1:0] issue_mask;

    always_comb begin
        issue_mask = '0;
        if (issue_valid) begin
            issue_mask[issue_engine] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= '0;
        end else begin
            busy <= (busy & ~engine_done) | issue_mask;
        end
    end

    assign can_issue = ~busy;
    assign all_idle  = ~|busy;

    assert property (@(posedge clk) disable iff (!rst_n)
        issue_valid |-> !busy[issue_engine]);
    // Engines only finish work they were given
    assert property (@(posedge clk) disable iff (!rst_n)
        (engine_done & ~busy) == '0);

endmodule

/* src/vec_engine.sv */
`timescale 1ns/1ps

module vec_engine
    import npu_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       cmd_valid,
    input  vec_cmd_t   cmd,
    output mem_rd_t    mem_rd,
    input  logic [7:0] mem_rd_data,
    output mem_wr_t    mem_wr,
    output logic       busy,
    output logic       done
);

    typedef enum logic [1:0] {S_IDLE, S_RD0, S_RD1, S_WR} state_t;

    state_t      state;
    vec_cmd_t    cmd_q;
    logic [15:0] idx;
    logic [7:0]  a_q;
    logic        two_op;
    logic        last;
    logic [7:0]  opa;
    logic [15:0] prod;
    logic [7:0]  result;
    logic [15:0] rd_sum;
    logic [15:0] wr_sum;

    assign two_op = !((cmd_q.op == VEC_COPY) || (cmd_q.op == VEC_SCALE));
    assign last   = (idx + 16'd1) == cmd_q.len;
    assign busy   = state != S_IDLE;

    // With two operands the src1 byte is on the read port, src0 sits in a_q
    assign opa  = two_op ? a_q : mem_rd_data;
    assign prod = opa * cmd_q.scale;

    always_comb begin
        case (cmd_q.op)
            VEC_ADD:   result = opa + mem_rd_data;
            VEC_SUB:   result = opa - mem_rd_data;
            VEC_SCALE: result = 8'(prod >> cmd_q.shift);
            default:   result = opa;
        endcase
    end

    // Single read port, so src0 and src1 go out on separate cycles
    assign rd_sum      = ((state == S_RD0) ? cmd_q.src0 : cmd_q.src1) + idx;
    assign wr_sum      = cmd_q.dst + idx;
    assign mem_rd.en   = (state == S_RD0) || (state == S_RD1);
    assign mem_rd.addr = rd_sum[DATA_AW-1:0];
    assign mem_wr.en   = state == S_WR;
    assign mem_wr.addr = wr_sum[DATA_AW-1:0];
    assign mem_wr.data = result;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
            idx   <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                S_IDLE: begin
                    idx <= '0;
                    if (cmd_valid) begin
                        if (cmd.len == '0) begin
                            done <= 1'b1;
                        end else begin
                            state <= S_RD0;
                        end
                    end
                end
                S_RD0: begin
                    state <= two_op ? S_RD1 : S_WR;
                end
                S_RD1: begin
                    state <= S_WR;
                end
                S_WR: begin
                    if (last) begin
                        state <= S_IDLE;
                        done  <= 1'b1;
                    end else begin
                        idx   <= idx + 16'd1;
                        state <= S_RD0;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && cmd_valid) begin
            cmd_q <= cmd;
        end
        if (state == S_RD1) begin
            a_q <= mem_rd_data;
        end
    end

endmodule

/* src/dma_shim.sv */
`timescale 1ns/1ps

module dma_shim
    import npu_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     cmd_valid,
    input  dma_cmd_t cmd,
    output logic     captured,
    output dma_cmd_t cmd_out,
    input  logic     ext_done,
    output logic     done
);

    logic active;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active   <= 1'b0;
            captured <= 1'b0;
        end else begin
            captured <= cmd_valid;
            if (cmd_valid) begin
                active <= 1'b1;
            end else if (ext_done) begin
                active <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_valid) begin
            cmd_out <= cmd;
        end
    end

    // Stray completions from the outside agent are dropped
    assign done = active && ext_done;

    assert property (@(posedge clk) disable iff (!rst_n) cmd_valid |-> !active);

endmodule

/* src/npu_ctrl_top.sv */
`timescale 1ns/1ps

module npu_ctrl_top
    import npu_pkg::*;
(
    input  logic           clk,
    input  logic           rst_n,
    input  logic           start,
    input  logic [UC_AW:0] ucode_len,
    output logic           program_end,
    input  ucode_wr_t      ucode_wr,
    input  mem_wr_t        mem_wr,
    input  mem_rd_t        mem_rd,
    output logic [7:0]     mem_rd_data,
    output logic           dma_cmd_captured,
    output dma_cmd_t       dma_cmd,
    input  logic           dma_done
);

    logic                   uc_rd_en;
    logic [UC_AW-1:0]       uc_rd_addr;
    ucode_instr_t           uc_rd_data;
    logic                   instr_valid;
    logic                   instr_ready;
    ucode_instr_t           instr;
    logic                   fetch_done;
    logic [NUM_ENGINES-1:0] can_issue;
    logic                   all_idle;
    logic                   vec_cmd_valid;
    vec_cmd_t               vec_cmd;
    logic                   dma_cmd_valid;
    dma_cmd_t               dec_dma_cmd;
    logic                   issue_valid;
    logic [ENG_W-1:0]       issue_engine;
    logic [NUM_ENGINES-1:0] engine_done;
    logic                   vec_busy;
    mem_rd_t                vec_rd;
    mem_wr_t                vec_wr;
    mem_rd_t                data_rd;
    mem_wr_t                data_wr;
    logic                   fetch_done_q;

    // =========================================================================
    // Microcode path
    // =========================================================================
    dp_sram #(.word_t(ucode_instr_t), .DEPTH(UC_DEPTH)) u_ucode_mem (
        .clk     (clk),
        .rd_en   (uc_rd_en),
        .rd_addr (uc_rd_addr),
        .rd_data (uc_rd_data),
        .wr_en   (ucode_wr.en),
        .wr_addr (ucode_wr.addr),
        .wr_data (ucode_instr_t'(ucode_wr.data))
    );

    ucode_fetch u_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .ucode_len   (ucode_len),
        .rd_en       (uc_rd_en),
        .rd_addr     (uc_rd_addr),
        .rd_data     (uc_rd_data),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_ready (instr_ready),
        .fetch_done  (fetch_done)
    );

    ucode_decode u_decode (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr_valid   (instr_valid),
        .instr         (instr),
        .instr_ready   (instr_ready),
        .can_issue     (can_issue),
        .all_idle      (all_idle),
        .vec_cmd_valid (vec_cmd_valid),
        .vec_cmd       (vec_cmd),
        .dma_cmd_valid (dma_cmd_valid),
        .dma_cmd       (dec_dma_cmd),
        .issue_valid   (issue_valid),
        .issue_engine  (issue_engine)
    );

    engine_scoreboard u_scoreboard (
        .clk          (clk),
        .rst_n        (rst_n),
        .issue_valid  (issue_valid),
        .issue_engine (issue_engine),
        .engine_done  (engine_done),
        .can_issue    (can_issue),
        .all_idle     (all_idle)
    );

    // =========================================================================
    // Engines and data memory
    // =========================================================================
    vec_engine u_vec (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd_valid   (vec_cmd_valid),
        .cmd         (vec_cmd),
        .mem_rd      (vec_rd),
        .mem_rd_data (mem_rd_data),
        .mem_wr      (vec_wr),
        .busy        (vec_busy),
        .done        (engine_done[ENG_VEC])
    );

    dma_shim u_dma (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_valid (dma_cmd_valid),
        .cmd       (dec_dma_cmd),
        .captured  (dma_cmd_captured),
        .cmd_out   (dma_cmd),
        .ext_done  (dma_done),
        .done      (engine_done[ENG_DMA])
    );

    // Vector engine owns both ports while busy
    assign data_rd = vec_busy ? vec_rd : mem_rd;
    assign data_wr = vec_busy ? vec_wr : mem_wr;

    dp_sram #(.word_t(logic [7:0]), .DEPTH(DATA_DEPTH)) u_data_mem (
        .clk     (clk),
        .rd_en   (data_rd.en),
        .rd_addr (data_rd.addr),
        .rd_data (mem_rd_data),
        .wr_en   (data_wr.en),
        .wr_addr (data_wr.addr),
        .wr_data (data_wr.data)
    );

    // =========================================================================
    // Program end, raised only once fetch is over and every engine drained
    // =========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_done_q <= 1'b0;
            program_end  <= 1'b0;
        end else if (start) begin
            fetch_done_q <= 1'b0;
            program_end  <= 1'b0;
        end else begin
            if (fetch_done) begin
                fetch_done_q <= 1'b1;
            end
            if (fetch_done_q && all_idle) begin
                program_end <= 1'b1;
            end
        end
    end

endmodule

/* verification/npu_tb.sv */
`timescale 1ns/1ps

module npu_tb
    import npu_pkg::*;
();

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 8;
    localparam int VEC_LEN      = 16;
    localparam int RUN_BOUND    = 200;
    localparam int DMA_HOLD     = 20;
    localparam int NUM_TESTS    = 9;

    // Worst-case cycle count of each test
    localparam int RESET_BUDGET    = 20;
    localparam int VEC_BUDGET      = 400;
    localparam int BARRIER_BUDGET  = 1100;
    localparam int DMA_BUDGET      = 250;
    localparam int WATCHDOG_CYCLES = RESET_BUDGET + 5 * VEC_BUDGET + BARRIER_BUDGET
                                     + 2 * DMA_BUDGET;

    logic           clk;
    logic           rst_n;
    logic           start;
    logic [UC_AW:0] ucode_len;
    logic           program_end;
    ucode_wr_t      ucode_wr;
    mem_wr_t        mem_wr;
    mem_rd_t        mem_rd;
    logic [7:0]     mem_rd_data;
    logic           dma_cmd_captured;
    dma_cmd_t       dma_cmd;
    logic           dma_done;

    integer seed;
    int     err_cnt;
    int     tests_passed;

    npu_ctrl_top dut (
        .clk              (clk),
        .rst_n            (rst_n),
        .start            (start),
        .ucode_len        (ucode_len),
        .program_end      (program_end),
        .ucode_wr         (ucode_wr),
        .mem_wr           (mem_wr),
        .mem_rd           (mem_rd),
        .mem_rd_data      (mem_rd_data),
        .dma_cmd_captured (dma_cmd_captured),
        .dma_cmd          (dma_cmd),
        .dma_done         (dma_done)
    );

    initial begin
        clk = 1'b0;
    end

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ========================================================================
    // Helpers for memory access and program control
    // ========================================================================
    function automatic logic [7:0] fill_byte(input logic [15:0] addr);
        return addr[7:0] ^ {addr[3:0], addr[11:8]} ^ 8'hA5;
    endfunction

    function automatic ucode_instr_t make_instr(
        input logic [7:0]  opcode,
        input logic [7:0]  flags,
        input logic [15:0] dst,
        input logic [15:0] src0,
        input logic [15:0] src1,
        input logic [15:0] len,
        input logic [15:0] imm
    );
        ucode_instr_t w;
        w        = '0;
        w.opcode = opcode;
        w.flags  = flags;
        w.dst    = dst;
        w.src0   = src0;
        w.src1   = src1;
        w.len    = len;
        w.imm    = imm;
        return w;
    endfunction

    // Expected byte per the vector rules
    function automatic logic [7:0] vec_model(
        input logic [1:0] op,
        input logic [7:0] a,
        input logic [7:0] b,
        input logic [7:0] scale,
        input logic [7:0] shift
    );
        int unsigned prod;
        prod = 32'(a) * 32'(scale);
        case (op)
            VEC_ADD:   return a + b;
            VEC_SUB:   return a - b;
            VEC_SCALE: return (shift >= 8'd16) ? 8'h00 : 8'(prod / (32'd1 << shift));
            VEC_COPY:  return a;
            default:   return 8'h00;
        endcase
    endfunction

    task automatic write_data(input logic [15:0] addr, input logic [7:0] val);
        @(negedge clk);
        mem_wr.en   = 1'b1;
        mem_wr.addr = addr[DATA_AW-1:0];
        mem_wr.data = val;
        @(negedge clk);
        mem_wr.en = 1'b0;
    endtask

    task automatic read_data(input logic [15:0] addr, output logic [7:0] val);
        @(negedge clk);
        mem_rd.en   = 1'b1;
        mem_rd.addr = addr[DATA_AW-1:0];
        @(negedge clk);
        mem_rd.en = 1'b0;
        val       = mem_rd_data;
    endtask

    task automatic write_ucode(input logic [UC_AW-1:0] addr, input ucode_instr_t w);
        @(negedge clk);
        ucode_wr.en   = 1'b1;
        ucode_wr.addr = addr;
        ucode_wr.data = w;
        @(negedge clk);
        ucode_wr.en = 1'b0;
    endtask

    task automatic start_program(input logic [UC_AW:0] n_words);
        @(negedge clk);
        ucode_len = n_words;
        start     = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic wait_program_end(input int bound);
        int cycles;
        cycles = 0;
        while (program_end !== 1'b1 && cycles < bound) begin
            @(negedge clk);
            cycles++;
        end
        if (program_end !== 1'b1) begin
            $display("program_end did not rise within %0d cycles", bound);
            err_cnt++;
        end
    endtask

    task automatic check_bytes(input logic [15:0] base, input logic [7:0] exp [VEC_LEN]);
        logic [7:0] got;
        for (int i = 0; i < VEC_LEN; i++) begin
            read_data(base + 16'(i), got);
            if (got !== exp[i]) begin
                $display("Error mem_rd_data @%03h: got %02h expected %02h",
                         base[11:0] + 12'(i), got, exp[i]);
                err_cnt++;
            end
        end
    endtask

    task automatic report_test(input string name, input int errs_at_start);
        if (err_cnt == errs_at_start) begin
            $display("%s: pass", name);
            tests_passed++;
        end else begin
            $display("%s: FAIL, %0d mismatches", name, err_cnt - errs_at_start);
        end
    endtask

    // ========================================================================
    // Tests
    // ========================================================================
    task automatic reset_test();
        int errs_at_start;
        errs_at_start = err_cnt;
        if (program_end !== 1'b0) begin
            $display("Error program_end: got %h expected 0", program_end);
            err_cnt++;
        end
        if (dma_cmd_captured !== 1'b0) begin
            $display("Error dma_cmd_captured: got %h expected 0", dma_cmd_captured);
            err_cnt++;
        end
        report_test("reset", errs_at_start);
    endtask

    // src0 sits at base, src1 at base + 0x10 and dst at base + 0x20
    task automatic vec_test(
        input string       name,
        input logic [1:0]  op,
        input logic [7:0]  scale,
        input logic [7:0]  shift,
        input logic [15:0] base
    );
        logic [7:0] a [VEC_LEN];
        logic [7:0] b [VEC_LEN];
        logic [7:0] exp [VEC_LEN];
        int         errs_at_start;
        errs_at_start = err_cnt;
        for (int i = 0; i < VEC_LEN; i++) begin
            a[i]   = 8'($random(seed));
            b[i]   = 8'($random(seed));
            exp[i] = vec_model(op, a[i], b[i], scale, shift);
            write_data(base + 16'(i), a[i]);
            write_data(base + 16'h10 + 16'(i), b[i]);
            write_data(base + 16'h20 + 16'(i), fill_byte(base + 16'h20 + 16'(i)));
        end
        write_ucode(8'd0, make_instr(OP_VEC, {6'd0, op}, base + 16'h20, base,
                                     base + 16'h10, 16'(VEC_LEN), {shift, scale}));
        write_ucode(8'd1, make_instr(OP_END, 8'h00, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0));
        start_program(9'd2);
        wait_program_end(RUN_BOUND);
        check_bytes(base + 16'h20, exp);
        report_test(name, errs_at_start);
    endtask

    task automatic dma_test(input string name, input logic is_write);
        dma_cmd_t exp_cmd;
        dma_cmd_t seen_cmd;
        int       pulses;
        int       cycles;
        logic     early_end;
        int       errs_at_start;
        errs_at_start    = err_cnt;
        pulses           = 0;
        early_end        = 1'b0;
        seen_cmd         = '0;
        exp_cmd.is_write = is_write;
        exp_cmd.src      = 16'($random(seed));
        exp_cmd.dst      = 16'($random(seed));
        exp_cmd.len      = 16'($random(seed));
        exp_cmd.flags    = 8'($random(seed));
        write_ucode(8'd0, make_instr(is_write ? OP_DMA_WR : OP_DMA_RD, exp_cmd.flags,
                                     exp_cmd.dst, exp_cmd.src, 16'h0, exp_cmd.len, 16'h0));
        write_ucode(8'd1, make_instr(OP_END, 8'h00, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0));
        start_program(9'd2);
        // The program must not end while completion is withheld
        repeat (DMA_HOLD) begin
            @(negedge clk);
            if (dma_cmd_captured === 1'b1) begin
                pulses++;
                seen_cmd = dma_cmd;
            end
            if (program_end !== 1'b0) begin
                early_end = 1'b1;
            end
        end
        if (early_end) begin
            $display("program_end rose while dma_done was withheld");
            err_cnt++;
        end
        @(negedge clk);
        dma_done = 1'b1;
        @(negedge clk);
        dma_done = 1'b0;
        cycles   = 0;
        while (program_end !== 1'b1 && cycles < RUN_BOUND) begin
            @(negedge clk);
            cycles++;
            if (dma_cmd_captured === 1'b1) begin
                pulses++;
            end
        end
        if (program_end !== 1'b1) begin
            $display("program_end did not rise after dma_done");
            err_cnt++;
        end
        if (pulses != 1) begin
            $display("Expected one dma_cmd_captured pulse but saw %0d", pulses);
            err_cnt++;
        end
        if (seen_cmd !== exp_cmd) begin
            $display("Error dma_cmd: got %h expected %h", seen_cmd, exp_cmd);
            err_cnt++;
        end
        report_test(name, errs_at_start);
    endtask

    // The DMA waits behind the barrier and the last op reads the first op's result
    task automatic barrier_test(input logic [15:0] base);
        logic [7:0] a [VEC_LEN];
        logic [7:0] b [VEC_LEN];
        logic [7:0] c [VEC_LEN];
        logic [7:0] d [VEC_LEN];
        int         cycles;
        int         errs_at_start;
        errs_at_start = err_cnt;
        for (int i = 0; i < VEC_LEN; i++) begin
            a[i] = 8'($random(seed));
            b[i] = 8'($random(seed));
            c[i] = vec_model(VEC_ADD, a[i], b[i], 8'h00, 8'h00);
            d[i] = vec_model(VEC_ADD, c[i], a[i], 8'h00, 8'h00);
            write_data(base + 16'(i), a[i]);
            write_data(base + 16'h10 + 16'(i), b[i]);
            write_data(base + 16'h20 + 16'(i), fill_byte(base + 16'h20 + 16'(i)));
            write_data(base + 16'h30 + 16'(i), fill_byte(base + 16'h30 + 16'(i)));
        end
        write_ucode(8'd0, make_instr(OP_VEC, {6'd0, VEC_ADD}, base + 16'h20, base,
                                     base + 16'h10, 16'(VEC_LEN), 16'h0));
        write_ucode(8'd1, make_instr(OP_BARRIER, 8'h00, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0));
        write_ucode(8'd2, make_instr(OP_DMA_RD, 8'h00, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0));
        write_ucode(8'd3, make_instr(OP_VEC, {6'd0, VEC_ADD}, base + 16'h30, base + 16'h20,
                                     base, 16'(VEC_LEN), 16'h0));
        write_ucode(8'd4, make_instr(OP_END, 8'h00, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0));
        start_program(9'd5);
        // One write port needs at least VEC_LEN cycles to finish the first op
        cycles = 0;
        while (dma_cmd_captured !== 1'b1 && cycles < 2 * RUN_BOUND) begin
            @(negedge clk);
            cycles++;
        end
        if (dma_cmd_captured !== 1'b1) begin
            $display("dma_cmd_captured did not pulse behind the barrier");
            err_cnt++;
        end else if (cycles < VEC_LEN) begin
            $display("DMA passed the barrier %0d cycles after start", cycles);
            err_cnt++;
        end
        @(negedge clk);
        dma_done = 1'b1;
        @(negedge clk);
        dma_done = 1'b0;
        wait_program_end(2 * RUN_BOUND);
        check_bytes(base + 16'h20, c);
        check_bytes(base + 16'h30, d);
        report_test("barrier_chain", errs_at_start);
    endtask

    // The second copy lies beyond ucode_len and must not run
    task automatic length_test(input logic [15:0] base);
        logic [7:0] a [VEC_LEN];
        logic [7:0] untouched [VEC_LEN];
        int         errs_at_start;
        errs_at_start = err_cnt;
        for (int i = 0; i < VEC_LEN; i++) begin
            a[i]         = 8'($random(seed));
            untouched[i] = fill_byte(base + 16'h20 + 16'(i));
            write_data(base + 16'(i), a[i]);
            write_data(base + 16'h10 + 16'(i), fill_byte(base + 16'h10 + 16'(i)));
            write_data(base + 16'h20 + 16'(i), untouched[i]);
        end
        write_ucode(8'd0, make_instr(OP_VEC, {6'd0, VEC_COPY}, base + 16'h10, base,
                                     16'h0, 16'(VEC_LEN), 16'h0));
        write_ucode(8'd1, make_instr(OP_VEC, {6'd0, VEC_COPY}, base + 16'h20, base,
                                     16'h0, 16'(VEC_LEN), 16'h0));
        write_ucode(8'd2, make_instr(OP_END, 8'h00, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0));
        start_program(9'd1);
        wait_program_end(RUN_BOUND);
        check_bytes(base + 16'h10, a);
        check_bytes(base + 16'h20, untouched);
        report_test("length_limit", errs_at_start);
    endtask

    // ========================================================================
    // Main sequence and watchdog
    // ========================================================================
    initial begin
        seed         = 93;
        err_cnt      = 0;
        tests_passed = 0;
        rst_n        = 1'b0;
        start        = 1'b0;
        ucode_len    = '0;
        ucode_wr     = '0;
        mem_wr       = '0;
        mem_rd       = '0;
        dma_done     = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        reset_test();
        vec_test("vec_add", VEC_ADD, 8'h00, 8'h00, 16'h0100);
        vec_test("vec_sub", VEC_SUB, 8'h00, 8'h00, 16'h0200);
        vec_test("vec_scale", VEC_SCALE, 8'hB7, 8'h05, 16'h0300);
        vec_test("vec_copy", VEC_COPY, 8'h00, 8'h00, 16'h0400);
        dma_test("dma_rd", 1'b0);
        dma_test("dma_wr", 1'b1);
        barrier_test(16'h0500);
        length_test(16'h0600);

        $display("Tests passed: %0d of %0d, errors: %0d", tests_passed, NUM_TESTS, err_cnt);
        if (err_cnt == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles before the tests finished", WATCHDOG_CYCLES);
        $display("Errors found");
        $finish;
    end

endmodule

/* vlog.f */
src/npu_pkg.sv
src/dp_sram.sv
src/ucode_fetch.sv
src/ucode_decode.sv
src/engine_scoreboard.sv
src/vec_engine.sv
src/dma_shim.sv
src/npu_ctrl_top.sv
verification/npu_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = npu_tb
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx 'No errors'

clean:
	rm -rf $(OBJ_DIR)
